/* hw/vc_settings.svh */
/*
 * Vector cluster settings
 * Cluster count, element width and slide limits
 */

`ifndef VC_SETTINGS_SVH
`define VC_SETTINGS_SVH

// Number of cluster elements on the ring
`define VC_NR_CLUSTERS 4

// Width of one vector element
`define VC_ELEN 32

// Cluster index and slide count widths
`define VC_ID_W 2
`define VC_CNT_W 3

`endif

/* hw/vc_pkg.sv */
/*
 * Vector cluster package
 * Opcodes, command payload views and the element type
 */

`include "vc_settings.svh"

package vc_pkg;

  typedef enum logic [1:0] {
    OP_SET   = 2'd0,
    OP_ADD   = 2'd1,
    OP_SLIDE = 2'd2,
    OP_READ  = 2'd3
  } vc_op_e;

  // One vector element, also the response word
  typedef logic [`VC_ELEN-1:0] vc_elem_t;

  // Slide view, dir_right moves elements toward higher index
  typedef struct packed {
    logic [`VC_ELEN-`VC_CNT_W-2:0] pad;
    logic                          dir_right;
    logic [`VC_CNT_W-1:0]          count;
  } vc_slide_t;

  // Read view
  typedef struct packed {
    logic [`VC_ELEN-`VC_ID_W-1:0] pad;
    logic [`VC_ID_W-1:0]          idx;
  } vc_read_t;

  // Same payload word, decoded by opcode
  typedef union packed {
    vc_elem_t  scalar;
    vc_slide_t slide;
    vc_read_t  read;
  } vc_payload_u;

  typedef struct packed {
    vc_op_e      op;
    vc_payload_u payload;
  } vc_cmd_t;

endpackage

/* hw/req_fork.sv */
/*
 * Request fork
 * Registers one host command and broadcasts it to every cluster and the
 * merge, freeing the register once all destinations have accepted
 */

`include "vc_settings.svh"

module req_fork import vc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  vc_cmd_t                    cmd_i,
  output logic [`VC_NR_CLUSTERS-1:0] pe_valid_o,
  input  logic [`VC_NR_CLUSTERS-1:0] pe_ready_i,
  output vc_cmd_t                    pe_cmd_o,
  output logic                       mrg_valid_o,
  input  logic                       mrg_ready_i,
  output vc_cmd_t                    mrg_cmd_o
);

  // Destination N is the merge, the rest are cluster elements
  logic                     full_q;
  vc_cmd_t                  cmd_q;
  logic [`VC_NR_CLUSTERS:0] done_q;
  logic [`VC_NR_CLUSTERS:0] dst_valid;
  logic [`VC_NR_CLUSTERS:0] dst_fire;
  logic                     all_done;

  assign dst_valid = {(`VC_NR_CLUSTERS+1){full_q}} & ~done_q;
  assign dst_fire  = dst_valid & {mrg_ready_i, pe_ready_i};
  assign all_done  = full_q & (&(done_q | dst_fire));

  // Free now, or freed in this cycle
  assign cmd_ready_o = ~full_q | all_done;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
      done_q <= '0;
    end else if (cmd_valid_i && cmd_ready_o) begin
      full_q <= 1'b1;
      done_q <= '0;
    end else if (all_done) begin
      full_q <= 1'b0;
      done_q <= '0;
    end else begin
      done_q <= done_q | dst_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
  end

  assign pe_valid_o  = dst_valid[`VC_NR_CLUSTERS-1:0];
  assign mrg_valid_o = dst_valid[`VC_NR_CLUSTERS];
  assign pe_cmd_o    = cmd_q;
  assign mrg_cmd_o   = cmd_q;

endmodule

/* hw/cluster_pe.sv */
/*
 * Cluster processing element
 * Holds one vector element, runs set/add/read locally and slides the
 * vector one ring hop per step through its own spill buffers
 */

`include "vc_settings.svh"

module cluster_pe import vc_pkg::*; #(
  parameter int unsigned ClusterId = 0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Command from the fork
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  input  vc_cmd_t  cmd_i,
  // Result to the merge
  output logic     res_valid_o,
  input  logic     res_ready_i,
  output vc_elem_t res_data_o,
  // Words leaving toward the neighbours
  output logic     ring_r_valid_o,
  input  logic     ring_r_ready_i,
  output vc_elem_t ring_r_data_o,
  output logic     ring_l_valid_o,
  input  logic     ring_l_ready_i,
  output vc_elem_t ring_l_data_o,
  // Words arriving from the neighbours
  input  logic     ring_from_l_valid_i,
  output logic     ring_from_l_ready_o,
  input  vc_elem_t ring_from_l_data_i,
  input  logic     ring_from_r_valid_i,
  output logic     ring_from_r_ready_o,
  input  vc_elem_t ring_from_r_data_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_RECV,
    ST_RES
  } pe_state_e;

  pe_state_e            state_q;
  vc_elem_t             elem_q;
  logic [`VC_CNT_W-1:0] cnt_q;
  logic                 dir_right_q;

  logic                 cmd_fire;
  logic                 in_valid;
  vc_elem_t             in_data;
  logic                 in_fire;

  // Spill buffers, index 0 goes right and index 1 goes left
  logic     [1:0] out_valid_q;
  vc_elem_t [1:0] out_data_q;
  logic     [1:0] out_ready;
  logic     [1:0] sel_dir;
  logic     [1:0] load;

  assign cmd_ready_o = (state_q == ST_IDLE);
  assign cmd_fire    = cmd_valid_i & cmd_ready_o;

  assign res_valid_o = (state_q == ST_RES);
  assign res_data_o  = elem_q;

  ////////////////////////////////////////////////////////////////////////////
  // Ring exchange
  ////////////////////////////////////////////////////////////////////////////

  assign out_ready = {ring_l_ready_i, ring_r_ready_i};
  assign sel_dir   = {~dir_right_q, dir_right_q};
  assign load      = {2{state_q == ST_SEND}} & sel_dir & (~out_valid_q | out_ready);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= '0;
    end else begin
      out_valid_q <= load | (out_valid_q & ~out_ready);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int d = 0; d < 2; d++) begin
      if (load[d]) begin
        out_data_q[d] <= elem_q;
      end
    end
  end

  assign ring_r_valid_o = out_valid_q[0];
  assign ring_r_data_o  = out_data_q[0];
  assign ring_l_valid_o = out_valid_q[1];
  assign ring_l_data_o  = out_data_q[1];

  // A right slide takes its new value from the left neighbour
  assign in_valid = dir_right_q ? ring_from_l_valid_i : ring_from_r_valid_i;
  assign in_data  = dir_right_q ? ring_from_l_data_i : ring_from_r_data_i;
  assign in_fire  = (state_q == ST_RECV) & in_valid;

  assign ring_from_l_ready_o = (state_q == ST_RECV) & dir_right_q;
  assign ring_from_r_ready_o = (state_q == ST_RECV) & ~dir_right_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      cnt_q       <= '0;
      dir_right_q <= 1'b0;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (cmd_fire) begin
            if (cmd_i.op == OP_SLIDE) begin
              dir_right_q <= cmd_i.payload.slide.dir_right;
              cnt_q       <= cmd_i.payload.slide.count;
              // Zero count leaves the vector as it is
              state_q     <= (cmd_i.payload.slide.count == '0) ? ST_RES : ST_SEND;
            end else begin
              state_q <= ST_RES;
            end
          end
        end
        ST_SEND: begin
          if (|load) begin
            state_q <= ST_RECV;
          end
        end
        ST_RECV: begin
          if (in_fire) begin
            cnt_q   <= cnt_q - 1'b1;
            state_q <= (cnt_q == 'd1) ? ST_RES : ST_SEND;
          end
        end
        ST_RES: begin
          if (res_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Element register
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      unique case (cmd_i.op)
        OP_SET:  elem_q <= cmd_i.payload.scalar + vc_elem_t'(ClusterId);
        OP_ADD:  elem_q <= elem_q + cmd_i.payload.scalar;
        default: elem_q <= elem_q;
      endcase
    end else if (in_fire) begin
      elem_q <= in_data;
    end
  end

endmodule

/* hw/resp_merge.sv */
/*
 * Response merge
 * Joins the results of all clusters and returns either their sum or the
 * element selected by a read
 */

`include "vc_settings.svh"

module resp_merge import vc_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 cmd_valid_i,
  output logic                                 cmd_ready_o,
  input  vc_cmd_t                              cmd_i,
  input  logic     [`VC_NR_CLUSTERS-1:0]       res_valid_i,
  input  vc_elem_t [`VC_NR_CLUSTERS-1:0]       res_data_i,
  output logic                                 res_ready_o,
  output logic                                 rsp_valid_o,
  input  logic                                 rsp_ready_i,
  output vc_elem_t                             rsp_data_o
);

  logic     slot_valid_q;
  vc_cmd_t  slot_cmd_q;
  logic     rsp_valid_q;
  vc_elem_t rsp_data_q;

  logic     join_fire;
  vc_elem_t sum;
  vc_elem_t result;

  // All results present, a command to pair them with, room in the output
  assign join_fire   = (&res_valid_i) & slot_valid_q & (~rsp_valid_q | rsp_ready_i);
  assign res_ready_o = join_fire;
  assign cmd_ready_o = ~slot_valid_q | join_fire;

  // Sum wraps at the element width
  always_comb begin
    sum = '0;
    for (int i = 0; i < `VC_NR_CLUSTERS; i++) begin
      sum = sum + res_data_i[i];
    end
    result = (slot_cmd_q.op == OP_READ) ? res_data_i[slot_cmd_q.payload.read.idx] : sum;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_valid_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
    end else begin
      if (cmd_valid_i && cmd_ready_o) begin
        slot_valid_q <= 1'b1;
      end else if (join_fire) begin
        slot_valid_q <= 1'b0;
      end
      if (join_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      slot_cmd_q <= cmd_i;
    end
    if (join_fire) begin
      rsp_data_q <= result;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

endmodule

/* hw/vec_cluster_top.sv */
/*
 * Vector cluster top level
 * Fork, ring of cluster elements and response merge
 */

`include "vc_settings.svh"

module vec_cluster_top import vc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  input  vc_cmd_t  cmd_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output vc_elem_t rsp_data_o
);

  localparam int unsigned N = `VC_NR_CLUSTERS;

  logic     [N-1:0] pe_valid;
  logic     [N-1:0] pe_ready;
  vc_cmd_t          pe_cmd;
  logic             mrg_valid;
  logic             mrg_ready;
  vc_cmd_t          mrg_cmd;

  logic     [N-1:0] res_valid;
  vc_elem_t [N-1:0] res_data;
  logic             res_ready;

  // Ring words, indexed by the sending cluster
  logic     [N-1:0] r_valid;
  logic     [N-1:0] r_ready;
  vc_elem_t [N-1:0] r_data;
  logic     [N-1:0] l_valid;
  logic     [N-1:0] l_ready;
  vc_elem_t [N-1:0] l_data;

  req_fork i_req_fork (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .pe_valid_o  (pe_valid),
    .pe_ready_i  (pe_ready),
    .pe_cmd_o    (pe_cmd),
    .mrg_valid_o (mrg_valid),
    .mrg_ready_i (mrg_ready),
    .mrg_cmd_o   (mrg_cmd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Cluster ring
  ////////////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < N; c++) begin : g_cluster
    localparam int unsigned Left  = (c == 0) ? N - 1 : c - 1;
    localparam int unsigned Right = (c == N - 1) ? 0 : c + 1;

    cluster_pe #(
      .ClusterId (c)
    ) i_cluster_pe (
      .clk_i               (clk_i),
      .rst_i               (rst_i),
      .cmd_valid_i         (pe_valid[c]),
      .cmd_ready_o         (pe_ready[c]),
      .cmd_i               (pe_cmd),
      .res_valid_o         (res_valid[c]),
      .res_ready_i         (res_ready),
      .res_data_o          (res_data[c]),
      .ring_r_valid_o      (r_valid[c]),
      .ring_r_ready_i      (r_ready[c]),
      .ring_r_data_o       (r_data[c]),
      .ring_l_valid_o      (l_valid[c]),
      .ring_l_ready_i      (l_ready[c]),
      .ring_l_data_o       (l_data[c]),
      // Left neighbour's right-going word and vice versa
      .ring_from_l_valid_i (r_valid[Left]),
      .ring_from_l_ready_o (r_ready[Left]),
      .ring_from_l_data_i  (r_data[Left]),
      .ring_from_r_valid_i (l_valid[Right]),
      .ring_from_r_ready_o (l_ready[Right]),
      .ring_from_r_data_i  (l_data[Right])
    );
  end

  resp_merge i_resp_merge (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (mrg_valid),
    .cmd_ready_o (mrg_ready),
    .cmd_i       (mrg_cmd),
    .res_valid_i (res_valid),
    .res_data_i  (res_data),
    .res_ready_o (res_ready),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

endmodule

/* tb/tb_vec_cluster.sv */
/*
 * Vector cluster testbench
 * Table-driven and random commands checked against a four-entry model
 */

`include "vc_settings.svh"

module tb_vec_cluster
  import vc_pkg::*;
();

  localparam int N          = `VC_NR_CLUSTERS;
  localparam int RAND_ROWS  = 32;
  localparam int CLK_PERIOD = 20;

  logic     clk_i;
  logic     rst_i;
  logic     cmd_valid_i;
  logic     cmd_ready_o;
  vc_cmd_t  cmd_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  vc_elem_t rsp_data_o;

  // Stimulus table, one entry per command
  string    row_name[$];
  vc_cmd_t  row_cmd[$];
  int       row_stall[$];
  vc_elem_t row_exp[$];

  vc_elem_t    model[N];
  logic [31:0] rng;
  int          table_rows;
  int          err_count;
  int          check_count;
  int          in_flight;
  int          max_in_flight;

  vec_cluster_top uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic vc_elem_t slide_word(input logic dir_right, input int count);
    vc_slide_t s;
    s           = '0;
    s.dir_right = dir_right;
    s.count     = `VC_CNT_W'(count);
    return vc_elem_t'(s);
  endfunction

  function automatic vc_elem_t read_word(input int idx);
    vc_read_t r;
    r     = '0;
    r.idx = `VC_ID_W'(idx);
    return vc_elem_t'(r);
  endfunction

  // Applies one command to the model and returns the expected response
  function automatic vc_elem_t model_apply(input vc_cmd_t c);
    vc_elem_t old_v[N];
    vc_elem_t sum;
    int       cm;
    int       src;
    sum   = '0;
    old_v = model;
    case (c.op)
      OP_SET: begin
        for (int i = 0; i < N; i++) model[i] = c.payload.scalar + vc_elem_t'(i);
      end
      OP_ADD: begin
        for (int i = 0; i < N; i++) model[i] = model[i] + c.payload.scalar;
      end
      OP_SLIDE: begin
        cm = int'(c.payload.slide.count) % N;
        for (int i = 0; i < N; i++) begin
          // Right moves toward higher index, so the source sits to the left
          if (c.payload.slide.dir_right) begin
            src = (i + N - cm) % N;
          end else begin
            src = (i + cm) % N;
          end
          model[i] = old_v[src];
        end
      end
      default: begin
      end
    endcase
    if (c.op == OP_READ) begin
      return model[c.payload.read.idx];
    end
    for (int i = 0; i < N; i++) sum = sum + model[i];
    return sum;
  endfunction

  task automatic add_row(input string name, input vc_op_e op, input vc_elem_t word,
                         input int stall, input vc_elem_t exp);
    vc_cmd_t c;
    c.op             = op;
    c.payload.scalar = word;
    row_name.push_back(name);
    row_cmd.push_back(c);
    row_stall.push_back(stall);
    row_exp.push_back(exp);
  endtask

  // Hand-derived expected values, each row follows from the one before
  task automatic build_table();
    add_row("set_100",      OP_SET,   32'd100,          6, 32'd406);
    add_row("read_0",       OP_READ,  read_word(0),     0, 32'd100);
    add_row("read_1",       OP_READ,  read_word(1),     0, 32'd101);
    add_row("read_2",       OP_READ,  read_word(2),     0, 32'd102);
    add_row("read_3",       OP_READ,  read_word(3),     0, 32'd103);
    add_row("add_5",        OP_ADD,   32'd5,            0, 32'd426);
    add_row("add_all_ones", OP_ADD,   32'hFFFF_FFFF,    3, 32'd422);
    add_row("slide_r1",     OP_SLIDE, slide_word(1, 1), 0, 32'd422);
    add_row("r1_read_0",    OP_READ,  read_word(0),     0, 32'd107);
    add_row("slide_l1",     OP_SLIDE, slide_word(0, 1), 0, 32'd422);
    add_row("l1_read_3",    OP_READ,  read_word(3),     0, 32'd107);
    add_row("slide_l3",     OP_SLIDE, slide_word(0, 3), 0, 32'd422);
    add_row("l3_read_0",    OP_READ,  read_word(0),     0, 32'd107);
    add_row("l3_read_1",    OP_READ,  read_word(1),     0, 32'd104);
    add_row("slide_r4",     OP_SLIDE, slide_word(1, 4), 0, 32'd422);
    add_row("r4_read_0",    OP_READ,  read_word(0),     0, 32'd107);
    add_row("r4_read_3",    OP_READ,  read_word(3),     0, 32'd106);
    add_row("slide_r7",     OP_SLIDE, slide_word(1, 7), 2, 32'd422);
    add_row("r7_read_0",    OP_READ,  read_word(0),     0, 32'd104);
    add_row("set_wrap",     OP_SET,   32'hFFFF_FFFE,    0, 32'hFFFF_FFFE);
    add_row("wrap_read_1",  OP_READ,  read_word(1),     0, 32'hFFFF_FFFF);
    add_row("wrap_read_2",  OP_READ,  read_word(2),     0, 32'd0);
    // Back to back under a long host stall
    add_row("stall_add_a",  OP_ADD,   32'd1,            5, 32'd2);
    add_row("stall_add_b",  OP_ADD,   32'd1,            5, 32'd6);
    add_row("stall_add_c",  OP_ADD,   32'd1,            5, 32'd10);
    add_row("stall_read_3", OP_READ,  read_word(3),     4, 32'd4);
  endtask

  task automatic add_random_rows(input int count);
    vc_cmd_t  c;
    vc_elem_t exp;
    int       stall;
    for (int k = 0; k < count; k++) begin
      rng  = xorshift32(rng);
      c.op = vc_op_e'(rng[1:0]);
      // First row sets a known vector for the model
      if (k == 0) c.op = OP_SET;
      rng = xorshift32(rng);
      case (c.op)
        OP_SLIDE: c.payload.scalar = slide_word(rng[31], int'(rng[15:0] % 16'd7) + 1);
        OP_READ:  c.payload.scalar = read_word(int'(rng[`VC_ID_W-1:0]));
        default:  c.payload.scalar = rng;
      endcase
      rng   = xorshift32(rng);
      stall = int'(rng[1:0]);
      exp   = model_apply(c);
      row_name.push_back($sformatf("rand_%0d", k));
      row_cmd.push_back(c);
      row_stall.push_back(stall);
      row_exp.push_back(exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_elem(input string name, input vc_elem_t exp, input vc_elem_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_idle(input string where);
    check_count++;
    if (rsp_valid_o !== 1'b0) begin
      err_count++;
      $display("%s: a response is valid although no command is pending", where);
    end
    if (cmd_ready_o !== 1'b1) begin
      err_count++;
      $display("%s: the cluster does not accept a new command", where);
    end
    if (in_flight != 0) begin
      err_count++;
      $display("%s: %0d commands never got a response", where, in_flight);
    end
  endtask

  // Handshake bookkeeping, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (rsp_valid_o && in_flight == 0) begin
        err_count++;
        $display("A response appeared with no command pending");
      end
      if (rsp_valid_o && rsp_ready_i && in_flight > 0) in_flight--;
      if (cmd_valid_i && cmd_ready_o) in_flight++;
      if (in_flight > max_in_flight) max_in_flight = in_flight;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_cmds(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      cmd_valid_i = 1'b1;
      cmd_i       = row_cmd[i];
      @(negedge clk_i);
      while (cmd_ready_o !== 1'b1) @(negedge clk_i);
      @(posedge clk_i);
      #2;
    end
    cmd_valid_i = 1'b0;
  endtask

  task automatic collect_rsp(input int idx);
    rsp_ready_i = (row_stall[idx] == 0);
    @(negedge clk_i);
    while (rsp_valid_o !== 1'b1) @(negedge clk_i);
    for (int s = 0; s < row_stall[idx]; s++) begin
      @(posedge clk_i);
      #2;
      if (s == row_stall[idx] - 1) rsp_ready_i = 1'b1;
      @(negedge clk_i);
      if (rsp_valid_o !== 1'b1) begin
        err_count++;
        $display("%s: response dropped while the host stalled", row_name[idx]);
      end
      check_elem({row_name[idx], "_held"}, row_exp[idx], rsp_data_o);
    end
    check_elem(row_name[idx], row_exp[idx], rsp_data_o);
    @(posedge clk_i);
    #2;
  endtask

  task automatic run_rows(input int first, input int last);
    fork
      send_cmds(first, last);
      begin
        for (int k = first; k <= last; k++) collect_rsp(k);
      end
    join
    rsp_ready_i = 1'b0;
  endtask

  // Watchdog, scaled by the number of commands
  initial begin
    int wd_time;
    #1;
    wd_time = row_name.size() * 40 * CLK_PERIOD;
    #(wd_time);
    $display("Timeout: run did not finish within %0d time units", wd_time);
    $display("Checks: %0d, errors: %0d, open commands: %0d", check_count, err_count,
             in_flight);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst_i         = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    rsp_ready_i   = 1'b0;
    err_count     = 0;
    check_count   = 0;
    in_flight     = 0;
    max_in_flight = 0;
    rng           = 32'd68654;
    build_table();
    table_rows = row_name.size();
    add_random_rows(RAND_ROWS);

    repeat (4) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    check_idle("After reset");

    run_rows(0, table_rows - 1);
    check_idle("After the table");
    check_count++;
    if (max_in_flight < 2) begin
      err_count++;
      $display("Fewer than two commands were in flight during the host stall");
    end

    run_rows(table_rows, table_rows + RAND_ROWS - 1);
    check_idle("After the random commands");

    $display("Checks: %0d, errors: %0d, max in flight: %0d", check_count, err_count,
             max_in_flight);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/vc_pkg.sv
hw/req_fork.sv
hw/cluster_pe.sv
hw/resp_merge.sv
hw/vec_cluster_top.sv
tb/tb_vec_cluster.sv

/* Makefile */
# Verilator flow for the vector cluster

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module vec_cluster_top

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_vec_cluster -o tb_sim
	./obj_dir/tb_sim > sim.log
	cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: lint sim clean
